// ==== src/npc_cfg.svh ====
// Sizes of the next-PC unit; NPC_RAS_DEPTH must be a power of two and indices start at pc bit 2
`ifndef NPC_CFG_SVH
`define NPC_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Base sizes
////////////////////////////////////////////////////////////////////////////

// Instruction address width
`define NPC_XLEN 32
// log2 of the direction counter count
`define NPC_DIRP_IDX_LEN 6
// log2 of the BTB entry count
`define NPC_BTB_IDX_LEN 5
// Return stack entries
`define NPC_RAS_DEPTH 8

////////////////////////////////////////////////////////////////////////////
// Derived sizes
////////////////////////////////////////////////////////////////////////////

`define NPC_DIRP_ENTRIES (1 << `NPC_DIRP_IDX_LEN)
`define NPC_BTB_ENTRIES (1 << `NPC_BTB_IDX_LEN)
// Upper pc bits kept as BTB tag
`define NPC_BTB_TAG_LEN (`NPC_XLEN - `NPC_BTB_IDX_LEN - 2)

`endif

// ==== src/npc_pkg.sv ====
// Shared types of the next-PC unit; all field widths come from the macros in npc_cfg.svh
`include "npc_cfg.svh"

package npc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Scalar types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [`NPC_XLEN-1:0]         addr_t;
    typedef logic [`NPC_DIRP_IDX_LEN-1:0] dirp_idx_t;
    typedef logic [`NPC_BTB_IDX_LEN-1:0]  btb_idx_t;
    typedef logic [`NPC_BTB_TAG_LEN-1:0]  btb_tag_t;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline records
    ////////////////////////////////////////////////////////////////////////////

    // One fetch slot as seen by the predictor
    typedef struct packed {
        addr_t pc;
        addr_t pc_plus_4;
        logic  is_branch;
        logic  is_jump;
        logic  is_return;
    } fetch_slot_t;

    // One result coming back from execute
    typedef struct packed {
        logic      valid;
        // Branch or jump with a computed target
        logic      is_ctrl;
        logic      taken;
        addr_t     pc;
        addr_t     target;
        dirp_idx_t dirp_idx;
    } resolve_t;

    // Prediction handed back for one slot
    typedef struct packed {
        addr_t     npc;
        logic      branch_predict;
        // Travels with the branch to execute
        dirp_idx_t dirp_tag;
    } predict_t;

endpackage

// ==== src/dirp_local.sv ====
// Local 2-bit direction counters; two same-index updates in one cycle apply slot 0 then slot 1
`timescale 1ns/100ps
`include "npc_cfg.svh"

module dirp_local (
    input  logic               clock,
    input  logic               rst,
    // Lookup side
    input  npc_pkg::addr_t     pc_0,
    input  npc_pkg::addr_t     pc_1,
    input  logic               is_branch_0,
    input  logic               is_branch_1,
    // Training side
    input  logic               upd_valid_0,
    input  logic               upd_valid_1,
    input  logic               upd_taken_0,
    input  logic               upd_taken_1,
    input  npc_pkg::dirp_idx_t upd_idx_0,
    input  npc_pkg::dirp_idx_t upd_idx_1,
    // Prediction
    output logic               taken_0,
    output logic               taken_1,
    output npc_pkg::dirp_idx_t tag_0,
    output npc_pkg::dirp_idx_t tag_1
);

    localparam int ENTRIES = `NPC_DIRP_ENTRIES;

    logic [1:0]         cnt [ENTRIES];
    npc_pkg::dirp_idx_t idx_0;
    npc_pkg::dirp_idx_t idx_1;
    logic               same_idx;

    // One saturating step up or down
    function automatic logic [1:0] sat_step(input logic [1:0] c, input logic up);
        logic [1:0] r;
        r = c;
        if (up && c != 2'b11) begin
            r = c + 2'b01;
        end else if (!up && c != 2'b00) begin
            r = c - 2'b01;
        end
        return r;
    endfunction

    assign idx_0 = pc_0[`NPC_DIRP_IDX_LEN+1:2];
    assign idx_1 = pc_1[`NPC_DIRP_IDX_LEN+1:2];

    // Index doubles as the tag sent down the pipe
    assign tag_0 = idx_0;
    assign tag_1 = idx_1;

    // Upper counter bit means taken
    assign taken_0 = is_branch_0 && cnt[idx_0][1];
    assign taken_1 = is_branch_1 && cnt[idx_1][1];

    assign same_idx = upd_valid_0 && upd_valid_1 && (upd_idx_0 == upd_idx_1);

    always_ff @(posedge clock) begin
        if (rst) begin
            // Weakly not-taken
            for (int i = 0; i < ENTRIES; i++) begin
                cnt[i] <= 2'b01;
            end
        end else if (same_idx) begin
            // Chain both steps so slot 1 lands on top of slot 0
            cnt[upd_idx_0] <= sat_step(sat_step(cnt[upd_idx_0], upd_taken_0), upd_taken_1);
        end else begin
            if (upd_valid_0) begin
                cnt[upd_idx_0] <= sat_step(cnt[upd_idx_0], upd_taken_0);
            end
            if (upd_valid_1) begin
                cnt[upd_idx_1] <= sat_step(cnt[upd_idx_1], upd_taken_1);
            end
        end
    end

endmodule

// ==== src/btb.sv ====
// Direct-mapped BTB with two read and two write ports; reads see old contents, slot 1 wins on conflict
`timescale 1ns/100ps
`include "npc_cfg.svh"

module btb (
    input  logic           clock,
    input  logic           rst,
    // Read ports
    input  logic           read_en_0,
    input  logic           read_en_1,
    input  npc_pkg::addr_t pc_r_0,
    input  npc_pkg::addr_t pc_r_1,
    // Write ports
    input  logic           write_en_0,
    input  logic           write_en_1,
    input  npc_pkg::addr_t pc_w_0,
    input  npc_pkg::addr_t pc_w_1,
    input  npc_pkg::addr_t target_w_0,
    input  npc_pkg::addr_t target_w_1,
    // Lookup result
    output npc_pkg::addr_t target_0,
    output npc_pkg::addr_t target_1,
    output logic           hit_0,
    output logic           hit_1
);

    localparam int ENTRIES = `NPC_BTB_ENTRIES;

    // Stored payload of one entry
    typedef struct packed {
        npc_pkg::btb_tag_t tag;
        npc_pkg::addr_t    target;
    } entry_t;

    entry_t               mem [ENTRIES];
    logic [ENTRIES-1:0]   valid;

    npc_pkg::btb_idx_t    ridx_0;
    npc_pkg::btb_idx_t    ridx_1;
    npc_pkg::btb_idx_t    widx_0;
    npc_pkg::btb_idx_t    widx_1;
    entry_t               rd_0;
    entry_t               rd_1;

    function automatic npc_pkg::btb_idx_t idx_of(input npc_pkg::addr_t pc);
        return pc[`NPC_BTB_IDX_LEN+1:2];
    endfunction

    function automatic npc_pkg::btb_tag_t tag_of(input npc_pkg::addr_t pc);
        return pc[`NPC_XLEN-1:`NPC_BTB_IDX_LEN+2];
    endfunction

    assign ridx_0 = idx_of(pc_r_0);
    assign ridx_1 = idx_of(pc_r_1);
    assign widx_0 = idx_of(pc_w_0);
    assign widx_1 = idx_of(pc_w_1);

    assign rd_0 = mem[ridx_0];
    assign rd_1 = mem[ridx_1];

    ////////////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////////////

    assign target_0 = rd_0.target;
    assign target_1 = rd_1.target;
    assign hit_0    = read_en_0 && valid[ridx_0] && (rd_0.tag == tag_of(pc_r_0));
    assign hit_1    = read_en_1 && valid[ridx_1] && (rd_1.tag == tag_of(pc_r_1));

    ////////////////////////////////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////////////////////////////////

    // Port 1 is written last so it takes a shared index
    always_ff @(posedge clock) begin
        if (rst) begin
            valid <= '0;
        end else begin
            if (write_en_0) begin
                valid[widx_0] <= 1'b1;
            end
            if (write_en_1) begin
                valid[widx_1] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_en_0) begin
            mem[widx_0] <= '{tag: tag_of(pc_w_0), target: target_w_0};
        end
        if (write_en_1) begin
            mem[widx_1] <= '{tag: tag_of(pc_w_1), target: target_w_1};
        end
    end

endmodule

// ==== src/ras.sv ====
// Circular return stack; overflow drops the oldest entry and squash empties it without recovery
`timescale 1ns/100ps
`include "npc_cfg.svh"

module ras (
    input  logic           clock,
    input  logic           rst,
    input  logic           squash,
    input  logic           push,
    input  logic           pop,
    input  npc_pkg::addr_t push_addr,
    output npc_pkg::addr_t top_addr,
    output logic           ras_valid
);

    localparam int DEPTH = `NPC_RAS_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    npc_pkg::addr_t   stack [DEPTH];
    // Next free slot, wraps around
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] top_ptr;
    logic [CNT_W-1:0] count;
    logic             empty;
    logic             full;
    logic             replace;

    assign top_ptr   = wr_ptr - 1'b1;
    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign ras_valid = !empty;
    assign top_addr  = stack[top_ptr];

    // Call and return in the same cycle on a non-empty stack
    assign replace = push && pop && !empty;

    ////////////////////////////////////////////////////////////////////////////
    // Pointer and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst || squash) begin
            wr_ptr <= '0;
            count  <= '0;
        end else if (push && !replace) begin
            wr_ptr <= wr_ptr + 1'b1;
            // Count saturates, oldest slot gets reused
            if (!full) begin
                count <= count + 1'b1;
            end
        end else if (pop && !push && !empty) begin
            wr_ptr <= top_ptr;
            count  <= count - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!squash && push) begin
            if (replace) begin
                stack[top_ptr] <= push_addr;
            end else begin
                stack[wr_ptr] <= push_addr;
            end
        end
    end

endmodule

// ==== src/npc_control.sv ====
// Two-slot next-PC prediction, combinational from fetch; resolves and stack ops land at the next edge
`timescale 1ns/100ps

module npc_control (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 squash,
    input  npc_pkg::fetch_slot_t fetch_0,
    input  npc_pkg::fetch_slot_t fetch_1,
    input  npc_pkg::resolve_t    resolve_0,
    input  npc_pkg::resolve_t    resolve_1,
    output npc_pkg::predict_t    predict_0,
    output npc_pkg::predict_t    predict_1
);

    npc_pkg::addr_t     btb_target_0;
    npc_pkg::addr_t     btb_target_1;
    npc_pkg::addr_t     ras_top;
    npc_pkg::addr_t     ras_push_addr;
    npc_pkg::dirp_idx_t dirp_tag_0;
    npc_pkg::dirp_idx_t dirp_tag_1;
    logic               btb_hit_0;
    logic               btb_hit_1;
    logic               dir_taken_0;
    logic               dir_taken_1;
    logic               bp_0;
    logic               bp_1;
    logic               ras_valid;
    logic               ras_push;
    logic               ras_pop;
    logic               upd_0;
    logic               upd_1;

    // Execute results that train both tables
    assign upd_0 = resolve_0.valid && resolve_0.is_ctrl;
    assign upd_1 = resolve_1.valid && resolve_1.is_ctrl;

    // Single stack op per cycle, slot 0 first
    assign ras_push      = fetch_0.is_jump || fetch_1.is_jump;
    assign ras_pop       = fetch_0.is_return || fetch_1.is_return;
    assign ras_push_addr = fetch_0.is_jump ? fetch_0.pc_plus_4 : fetch_1.pc_plus_4;

    // Taken only counts with a known target
    assign bp_0 = dir_taken_0 && btb_hit_0;
    assign bp_1 = dir_taken_1 && btb_hit_1;

    ////////////////////////////////////////////////////////////////////////////
    // Next-PC selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        predict_0.dirp_tag       = dirp_tag_0;
        predict_0.branch_predict = bp_0;
        if (fetch_0.is_return && ras_valid) begin
            predict_0.npc = ras_top;
        end else if ((fetch_0.is_jump && btb_hit_0) || bp_0) begin
            predict_0.npc = btb_target_0;
        end else begin
            predict_0.npc = fetch_0.pc_plus_4;
        end
    end

    // Slot 1 gets the stack top only when slot 0 did not take it
    always_comb begin
        predict_1.dirp_tag       = dirp_tag_1;
        predict_1.branch_predict = bp_1;
        if (!fetch_0.is_return && fetch_1.is_return && ras_valid) begin
            predict_1.npc = ras_top;
        end else if ((fetch_1.is_jump && btb_hit_1) || bp_1) begin
            predict_1.npc = btb_target_1;
        end else begin
            predict_1.npc = fetch_1.pc_plus_4;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Storage blocks
    ////////////////////////////////////////////////////////////////////////////

    dirp_local dirp_0 (
        .clock(clock), .rst(rst),
        .pc_0(fetch_0.pc), .pc_1(fetch_1.pc),
        .is_branch_0(fetch_0.is_branch), .is_branch_1(fetch_1.is_branch),
        .upd_valid_0(upd_0), .upd_valid_1(upd_1),
        .upd_taken_0(resolve_0.taken), .upd_taken_1(resolve_1.taken),
        .upd_idx_0(resolve_0.dirp_idx), .upd_idx_1(resolve_1.dirp_idx),
        .taken_0(dir_taken_0), .taken_1(dir_taken_1),
        .tag_0(dirp_tag_0), .tag_1(dirp_tag_1)
    );

    btb btb_0 (
        .clock(clock), .rst(rst),
        .read_en_0(fetch_0.is_branch || fetch_0.is_jump),
        .read_en_1(fetch_1.is_branch || fetch_1.is_jump),
        .pc_r_0(fetch_0.pc), .pc_r_1(fetch_1.pc),
        .write_en_0(upd_0), .write_en_1(upd_1),
        .pc_w_0(resolve_0.pc), .pc_w_1(resolve_1.pc),
        .target_w_0(resolve_0.target), .target_w_1(resolve_1.target),
        .target_0(btb_target_0), .target_1(btb_target_1),
        .hit_0(btb_hit_0), .hit_1(btb_hit_1)
    );

    ras ras_0 (
        .clock(clock), .rst(rst), .squash(squash),
        .push(ras_push), .pop(ras_pop), .push_addr(ras_push_addr),
        .top_addr(ras_top), .ras_valid(ras_valid)
    );

endmodule

// ==== verification/npc_control_assert.sv ====
// Bound to npc_control; sampled on the rising clock and idle while rst is high
`timescale 1ns/100ps

module npc_control_assert (
    input logic                 clock,
    input logic                 rst,
    input logic                 squash,
    input npc_pkg::fetch_slot_t fetch_0,
    input npc_pkg::fetch_slot_t fetch_1,
    input npc_pkg::predict_t    predict_0,
    input npc_pkg::predict_t    predict_1,
    input logic                 ras_valid
);

    // Taken prediction only on a branch
    bp_branch_0: assert property (@(posedge clock) disable iff (rst)
        predict_0.branch_predict |-> fetch_0.is_branch)
        else $error("slot 0 predicted taken on a non-branch");
    bp_branch_1: assert property (@(posedge clock) disable iff (rst)
        predict_1.branch_predict |-> fetch_1.is_branch)
        else $error("slot 1 predicted taken on a non-branch");

    // Redirect needs a control instruction
    redirect_0: assert property (@(posedge clock) disable iff (rst)
        (predict_0.npc != fetch_0.pc_plus_4) |->
        (fetch_0.is_jump || fetch_0.is_branch || fetch_0.is_return))
        else $error("slot 0 redirected without a control instruction");
    redirect_1: assert property (@(posedge clock) disable iff (rst)
        (predict_1.npc != fetch_1.pc_plus_4) |->
        (fetch_1.is_jump || fetch_1.is_branch || fetch_1.is_return))
        else $error("slot 1 redirected without a control instruction");

    squash_empty: assert property (@(posedge clock) disable iff (rst)
        squash |=> !ras_valid)
        else $error("return stack still valid after squash");

endmodule

bind npc_control npc_control_assert assert0 (
    .clock(clock), .rst(rst), .squash(squash),
    .fetch_0(fetch_0), .fetch_1(fetch_1),
    .predict_0(predict_0), .predict_1(predict_1),
    .ras_valid(ras_valid)
);

// ==== verification/npc_control_tb.sv ====
// npc_control testbench; PCs come from a 16-entry pool so table indices collide on purpose
`timescale 1ns/100ps
`include "npc_cfg.svh"

module npc_control_tb;

    localparam int DEPTH   = `NPC_RAS_DEPTH;
    localparam int TIMEOUT = 8;

    logic                 clock;
    logic                 rst;
    logic                 squash;
    npc_pkg::fetch_slot_t fetch_0;
    npc_pkg::fetch_slot_t fetch_1;
    npc_pkg::resolve_t    resolve_0;
    npc_pkg::resolve_t    resolve_1;
    npc_pkg::predict_t    predict_0;
    npc_pkg::predict_t    predict_1;
    npc_pkg::predict_t    last_0;
    npc_pkg::predict_t    last_1;

    // Reference state
    logic [1:0]     m_cnt [`NPC_DIRP_ENTRIES];
    logic           m_valid [`NPC_BTB_ENTRIES];
    npc_pkg::addr_t m_tag [`NPC_BTB_ENTRIES];
    npc_pkg::addr_t m_target [`NPC_BTB_ENTRIES];
    npc_pkg::addr_t m_stack [DEPTH];
    int             m_ptr;
    int             m_count;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          test_base;

    npc_control dut0 (
        .clock(clock), .rst(rst), .squash(squash),
        .fetch_0(fetch_0), .fetch_1(fetch_1),
        .resolve_0(resolve_0), .resolve_1(resolve_1),
        .predict_0(predict_0), .predict_1(predict_1)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic npc_pkg::addr_t pool_pc();
        logic [31:0] t;
        logic [31:0] i;
        t = rand_bits(2);
        i = rand_bits(2);
        return 32'h0000_1000 | (t << 7) | (i << 2);
    endfunction

    // Kind 1 is a branch, 2 a jump and 3 a return
    function automatic npc_pkg::fetch_slot_t mk_fetch(input npc_pkg::addr_t pc, input int kind);
        npc_pkg::fetch_slot_t f;
        f.pc        = pc;
        f.pc_plus_4 = pc + 32'd4;
        f.is_branch = (kind == 1);
        f.is_jump   = (kind == 2);
        f.is_return = (kind == 3);
        return f;
    endfunction

    function automatic npc_pkg::resolve_t mk_resolve(input npc_pkg::addr_t pc,
                                                     input npc_pkg::addr_t target,
                                                     input logic taken);
        npc_pkg::resolve_t r;
        r.valid    = 1'b1;
        r.is_ctrl  = 1'b1;
        r.taken    = taken;
        r.pc       = pc;
        r.target   = target;
        r.dirp_idx = pc[`NPC_DIRP_IDX_LEN+1:2];
        return r;
    endfunction

    function automatic npc_pkg::fetch_slot_t rand_fetch(input logic no_return);
        int kind;
        kind = int'(rand_bits(2));
        if (no_return && kind == 3) begin
            kind = 1;
        end
        return mk_fetch(pool_pc(), kind);
    endfunction

    function automatic npc_pkg::resolve_t rand_resolve();
        npc_pkg::resolve_t r;
        r.valid    = rand_bits(1) != '0;
        r.is_ctrl  = rand_bits(1) != '0;
        r.taken    = rand_bits(1) != '0;
        r.pc       = pool_pc();
        r.target   = rand_bits(30) << 2;
        r.dirp_idx = r.pc[`NPC_DIRP_IDX_LEN+1:2];
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic int btb_index(input npc_pkg::addr_t pc);
        return int'(pc[`NPC_BTB_IDX_LEN+1:2]);
    endfunction

    function automatic npc_pkg::addr_t upper_bits(input npc_pkg::addr_t pc);
        return pc >> (`NPC_BTB_IDX_LEN + 2);
    endfunction

    function automatic npc_pkg::predict_t expect_slot(input npc_pkg::fetch_slot_t f,
                                                      input logic may_pop);
        npc_pkg::predict_t p;
        int                bi;
        logic              hit;
        bi    = btb_index(f.pc);
        hit   = (f.is_branch || f.is_jump) && m_valid[bi] && (m_tag[bi] == upper_bits(f.pc));
        p.dirp_tag       = f.pc[`NPC_DIRP_IDX_LEN+1:2];
        p.branch_predict = f.is_branch && m_cnt[int'(p.dirp_tag)][1] && hit;
        if (may_pop && f.is_return && m_count != 0) begin
            p.npc = m_stack[(m_ptr + DEPTH - 1) % DEPTH];
        end else if ((f.is_jump && hit) || p.branch_predict) begin
            p.npc = m_target[bi];
        end else begin
            p.npc = f.pc_plus_4;
        end
        return p;
    endfunction

    function automatic void train(input npc_pkg::resolve_t r);
        int di;
        int bi;
        if (r.valid && r.is_ctrl) begin
            di = int'(r.dirp_idx);
            bi = btb_index(r.pc);
            if (r.taken && m_cnt[di] != 2'b11) begin
                m_cnt[di] = m_cnt[di] + 2'b01;
            end else if (!r.taken && m_cnt[di] != 2'b00) begin
                m_cnt[di] = m_cnt[di] - 2'b01;
            end
            m_valid[bi]  = 1'b1;
            m_tag[bi]    = upper_bits(r.pc);
            m_target[bi] = r.target;
        end
    endfunction

    // Effect of one rising edge with slot 0 applied before slot 1
    function automatic void model_edge(input npc_pkg::fetch_slot_t f0,
                                       input npc_pkg::fetch_slot_t f1,
                                       input npc_pkg::resolve_t r0,
                                       input npc_pkg::resolve_t r1,
                                       input logic sq);
        logic           push;
        logic           pop;
        npc_pkg::addr_t addr;
        train(r0);
        train(r1);
        push = f0.is_jump || f1.is_jump;
        pop  = f0.is_return || f1.is_return;
        addr = f0.is_jump ? f0.pc_plus_4 : f1.pc_plus_4;
        if (sq) begin
            m_count = 0;
        end else if (push && pop && m_count != 0) begin
            m_stack[(m_ptr + DEPTH - 1) % DEPTH] = addr;
        end else if (push) begin
            m_stack[m_ptr] = addr;
            m_ptr = (m_ptr + 1) % DEPTH;
            if (m_count < DEPTH) begin
                m_count++;
            end
        end else if (pop && m_count != 0) begin
            m_ptr = (m_ptr + DEPTH - 1) % DEPTH;
            m_count--;
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks and cycle driver
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_addr(input string name, input npc_pkg::addr_t exp,
                              input npc_pkg::addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_predict(input string name, input npc_pkg::predict_t exp,
                                 input npc_pkg::predict_t act);
        check_addr({name, ".npc"}, exp.npc, act.npc);
        checks += 2;
        if (act.branch_predict !== exp.branch_predict) begin
            errors++;
            $display("FAIL %0t %s.branch_predict expected %b actual %b", $time, name,
                     exp.branch_predict, act.branch_predict);
        end
        if (act.dirp_tag !== exp.dirp_tag) begin
            errors++;
            $display("FAIL %0t %s.dirp_tag expected %h actual %h", $time, name,
                     exp.dirp_tag, act.dirp_tag);
        end
    endtask

    // Entered 0.5 ns after an edge and checks 0.5 ns before the next one
    task automatic run_cycle(input npc_pkg::fetch_slot_t f0, input npc_pkg::fetch_slot_t f1,
                             input npc_pkg::resolve_t r0, input npc_pkg::resolve_t r1,
                             input logic sq);
        fetch_0   = f0;
        fetch_1   = f1;
        resolve_0 = r0;
        resolve_1 = r1;
        squash    = sq;
        #3;
        check_predict("predict_0", expect_slot(f0, 1'b1), predict_0);
        check_predict("predict_1", expect_slot(f1, !f0.is_return), predict_1);
        last_0 = predict_0;
        last_1 = predict_1;
        model_edge(f0, f1, r0, r1, sq);
        @(posedge clock);
        #0.5;
    endtask

    task automatic fetch_only(input npc_pkg::fetch_slot_t f0, input npc_pkg::fetch_slot_t f1);
        run_cycle(f0, f1, '0, '0, 1'b0);
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        npc_pkg::fetch_slot_t f0;
        npc_pkg::fetch_slot_t f1;
        npc_pkg::fetch_slot_t nop;
        npc_pkg::addr_t       pa;
        npc_pkg::addr_t       pb;
        npc_pkg::addr_t       pc2;
        int                   n;
        logic                 done;
        lfsr      = 32'h6fa98526;
        errors    = 0;
        checks    = 0;
        test_base = 0;
        rst       = 1'b1;
        squash    = 1'b0;
        fetch_0   = '0;
        fetch_1   = '0;
        resolve_0 = '0;
        resolve_1 = '0;
        nop       = mk_fetch(32'h0000_0100, 0);
        for (int i = 0; i < `NPC_DIRP_ENTRIES; i++) begin
            m_cnt[i] = 2'b01;
        end
        for (int i = 0; i < `NPC_BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        m_ptr   = 0;
        m_count = 0;
        repeat (5) @(posedge clock);
        #0.5;
        rst = 1'b0;

        // Nothing learned yet so every slot falls through
        for (int i = 0; i < 20; i++) begin
            f0 = rand_fetch(1'b1);
            f1 = rand_fetch(1'b1);
            fetch_only(f0, f1);
            check_addr("predict_0.npc", f0.pc_plus_4, last_0.npc);
            check_addr("predict_1.npc", f1.pc_plus_4, last_1.npc);
        end
        run_cycle(nop, nop, '0, '0, 1'b1);
        end_test("reset_state");

        pa = 32'h0000_1008;
        for (int i = 0; i < 4; i++) begin
            run_cycle(mk_fetch(pa, 1), nop, mk_resolve(pa, 32'h0000_4000, 1'b1), '0, 1'b0);
        end
        fetch_only(mk_fetch(pa, 1), nop);
        check_addr("predict_0.npc", 32'h0000_4000, last_0.npc);
        for (int i = 0; i < 4; i++) begin
            run_cycle(mk_fetch(pa, 1), nop, mk_resolve(pa, 32'h0000_4000, 1'b0), '0, 1'b0);
        end
        // Two updates on one counter in the same cycle apply slot 0 first
        run_cycle(mk_fetch(pa, 1), mk_fetch(pa, 1), mk_resolve(pa, 32'h0000_4000, 1'b1),
                  mk_resolve(pa, 32'h0000_4000, 1'b1), 1'b0);
        run_cycle(mk_fetch(pa, 1), mk_fetch(pa, 1), mk_resolve(pa, 32'h0000_4000, 1'b1),
                  mk_resolve(pa, 32'h0000_4000, 1'b1), 1'b0);
        run_cycle(mk_fetch(pa, 1), mk_fetch(pa, 1), mk_resolve(pa, 32'h0000_4000, 1'b1),
                  mk_resolve(pa, 32'h0000_4000, 1'b0), 1'b0);
        run_cycle(mk_fetch(pa, 1), nop, mk_resolve(pa, 32'h0000_4000, 1'b0), '0, 1'b0);
        fetch_only(mk_fetch(pa, 1), mk_fetch(pa, 1));
        end_test("direction_training");

        pb  = 32'h0000_2010;
        pc2 = pb + (32'd1 << (`NPC_BTB_IDX_LEN + 2));
        run_cycle(nop, nop, mk_resolve(pb, 32'h0000_5000, 1'b1), '0, 1'b0);
        fetch_only(mk_fetch(pb, 2), nop);
        check_addr("predict_0.npc", 32'h0000_5000, last_0.npc);
        run_cycle(nop, nop, mk_resolve(pc2, 32'h0000_6000, 1'b1), '0, 1'b0);
        fetch_only(mk_fetch(pb, 2), mk_fetch(pc2, 2));
        check_addr("predict_0.npc", pb + 32'd4, last_0.npc);
        check_addr("predict_1.npc", 32'h0000_6000, last_1.npc);
        run_cycle(nop, nop, mk_resolve(pb, 32'h0000_7000, 1'b1),
                  mk_resolve(pb, 32'h0000_8000, 1'b1), 1'b0);
        fetch_only(mk_fetch(pb, 2), nop);
        check_addr("predict_0.npc", 32'h0000_8000, last_0.npc);
        run_cycle(nop, nop, '0, '0, 1'b1);
        end_test("btb");

        for (int i = 0; i < 3; i++) begin
            fetch_only(mk_fetch(32'h0000_3000 + 16 * i, 2), nop);
        end
        for (int i = 2; i >= 0; i--) begin
            fetch_only(mk_fetch(32'h0000_3800, 3), nop);
            check_addr("predict_0.npc", 32'h0000_3004 + 16 * i, last_0.npc);
        end
        // Two calls past the depth drop the two oldest
        for (int i = 0; i < DEPTH + 2; i++) begin
            fetch_only(mk_fetch(32'h0000_3000 + 16 * i, 2), nop);
        end
        for (int i = DEPTH + 1; i >= 2; i--) begin
            fetch_only(mk_fetch(32'h0000_3800, 3), nop);
            check_addr("predict_0.npc", 32'h0000_3004 + 16 * i, last_0.npc);
        end
        fetch_only(mk_fetch(32'h0000_3800, 3), nop);
        check_addr("predict_0.npc", 32'h0000_3804, last_0.npc);
        fetch_only(mk_fetch(32'h0000_3100, 2), nop);
        fetch_only(mk_fetch(32'h0000_3110, 2), nop);
        fetch_only(mk_fetch(32'h0000_3120, 2), mk_fetch(32'h0000_3800, 3));
        check_addr("predict_1.npc", 32'h0000_3114, last_1.npc);
        fetch_only(mk_fetch(32'h0000_3800, 3), nop);
        check_addr("predict_0.npc", 32'h0000_3124, last_0.npc);
        fetch_only(mk_fetch(32'h0000_3800, 3), nop);
        check_addr("predict_0.npc", 32'h0000_3104, last_0.npc);
        end_test("return_stack");

        fetch_only(mk_fetch(32'h0000_3100, 2), nop);
        fetch_only(mk_fetch(32'h0000_3110, 2), nop);
        run_cycle(nop, nop, '0, '0, 1'b1);
        n    = 0;
        done = 1'b0;
        while (!done) begin
            fetch_only(mk_fetch(32'h0000_3800, 3), nop);
            n++;
            if (last_0.npc == 32'h0000_3804) begin
                done = 1'b1;
            end else if (n >= TIMEOUT) begin
                $display("Timeout: return still predicted from the stack %0d cycles %s",
                         n, "after squash");
                errors++;
                done = 1'b1;
            end
        end
        fetch_only(mk_fetch(32'h0000_3100, 2), nop);
        fetch_only(mk_fetch(32'h0000_3110, 2), nop);
        fetch_only(mk_fetch(32'h0000_3800, 3), mk_fetch(32'h0000_3900, 3));
        check_addr("predict_0.npc", 32'h0000_3114, last_0.npc);
        check_addr("predict_1.npc", 32'h0000_3904, last_1.npc);
        fetch_only(mk_fetch(32'h0000_3800, 3), nop);
        check_addr("predict_0.npc", 32'h0000_3104, last_0.npc);
        end_test("squash_priority");

        for (int i = 0; i < 2000; i++) begin
            f0 = rand_fetch(1'b0);
            f1 = rand_fetch(1'b0);
            run_cycle(f0, f1, rand_resolve(), rand_resolve(), rand_bits(4) == 32'd0);
        end
        end_test("mixed_random");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== npc_control.f ====
+incdir+src
src/npc_pkg.sv
src/dirp_local.sv
src/btb.sv
src/ras.sv
src/npc_control.sv
verification/npc_control_assert.sv
verification/npc_control_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the npc_control testbench with Verilator, verdict from sim.log
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module npc_control_tb -f npc_control.f \
    --Mdir obj_dir -o npc_control_sim > build.log 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/npc_control_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
